// File: rp32_core.f
hdl/rp_pkg.sv
hdl/rp_ctl_if.sv
hdl/rp_dec.sv
hdl/rp_gpr.sv
hdl/rp_alu.sv
hdl/rp_br.sv
hdl/rp32_core.sv
testbench/rp_tb_clk.sv
testbench/rp_tb_mem.sv
testbench/rp32_core_tb.sv

// File: Bender.yml
package:
  name: rp32_core

sources:
  - hdl/rp_pkg.sv
  - hdl/rp_ctl_if.sv
  - hdl/rp_dec.sv
  - hdl/rp_gpr.sv
  - hdl/rp_alu.sv
  - hdl/rp_br.sv
  - hdl/rp32_core.sv
  - target: test
    files:
      - testbench/rp_tb_clk.sv
      - testbench/rp_tb_mem.sv
      - testbench/rp32_core_tb.sv

// File: testbench/rp32_core_tb.sv
`timescale 1ns/100ps

module rp32_core_tb;

  logic        clk;
  logic        rst;
  logic        rerun;
  logic        bup_req;
  logic [31:0] bup_adr;
  logic [31:0] bup_rdt;
  logic        bup_ack;
  logic        bud_req;
  logic        bud_wen;
  logic [3:0]  bud_sel;
  logic [31:0] bud_adr;
  logic [31:0] bud_wdt;
  logic [31:0] bud_rdt;
  logic        bud_ack;
  logic        done;

  int unsigned errors;
  int unsigned checks;
  int unsigned seed;
  logic [31:0] prog [$];

  rp_tb_clk clkgen (.rerun(rerun), .clk(clk), .rst(rst));

  rp_tb_mem mem (
    .clk(clk), .bup_req(bup_req), .bup_adr(bup_adr), .bup_rdt(bup_rdt), .bup_ack(bup_ack),
    .bud_req(bud_req), .bud_wen(bud_wen), .bud_sel(bud_sel), .bud_adr(bud_adr),
    .bud_wdt(bud_wdt), .bud_rdt(bud_rdt), .bud_ack(bud_ack), .done(done)
  );

  rp32_core #(.RVE(0), .PC0(32'h0000_0000)) uut (
    .clk(clk), .rst(rst), .bup_req(bup_req), .bup_adr(bup_adr), .bup_rdt(bup_rdt),
    .bup_ack(bup_ack), .bud_req(bud_req), .bud_wen(bud_wen), .bud_sel(bud_sel),
    .bud_adr(bud_adr), .bud_wdt(bud_wdt), .bud_rdt(bud_rdt), .bud_ack(bud_ack)
  );

  // every fetch address is word aligned
  always @(negedge clk) begin
    if (bup_req && (bup_adr[1:0] != 2'b00)) begin
      errors++;
      $display("ERR %0t: fetch address %h not word aligned", $time, bup_adr);
    end
  end

  ////////////////////////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                        int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rp_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                        logic [6:0] op);
    return {imm, rs1[4:0], f3, rd[4:0], op};
  endfunction

  // sw rs2, imm(rs1)
  function automatic logic [31:0] enc_sw(logic [11:0] imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rp_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
            rp_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, int rd, logic [6:0] op);
    return {imm, rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rp_pkg::OPC_JAL};
  endfunction

  ////////////////////////////////////////////////////////////
  // reference results by the RV32I rules
  ////////////////////////////////////////////////////////////

  // k follows the order add sub sll slt sltu xor srl sra or and
  function automatic logic [31:0] expect_r(int k, logic [31:0] a, logic [31:0] b);
    case (k)
      0: return a + b;
      1: return a - b;
      2: return a << b[4:0];
      3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4: return (a < b) ? 32'd1 : 32'd0;
      5: return a ^ b;
      6: return a >> b[4:0];
      7: return $signed(a) >>> b[4:0];
      8: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // data word that no store has touched
  function automatic logic [31:0] fill_word(int idx);
    return 32'ha5a5_0000 ^ (32'(idx) << 2);
  endfunction

  ////////////////////////////////////////////////////////////
  // program loading and run control
  ////////////////////////////////////////////////////////////

  task automatic check_word(string what, int idx, logic [31:0] exp);
    checks++;
    if (mem.dmem[idx] !== exp) begin
      errors++;
      $display("ERR %0t: %s word %0d got %h expected %h", $time, what, idx,
               mem.dmem[idx], exp);
    end
  endtask

  // reset the core and load prog while it is held
  task automatic start_run();
    int n;
    rerun <= 1'b1;
    @(negedge clk);
    rerun <= 1'b0;
    n = 0;
    while (!rst && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!rst) begin
      errors++;
      $display("reset did not assert after restart request");
    end
    for (int i = 0; i < 256; i++) begin
      // unused words hold a self-loop
      mem.pmem[i] = (i < prog.size()) ? prog[i] : enc_j(21'd0, 0);
      mem.dmem[i] = fill_word(i);
    end
    mem.done = 1'b0;
  endtask

  // wait for the marker store
  task automatic finish_run(string what);
    int n;
    n = 0;
    while (!done && n < 4000) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      errors++;
      $display("%s program never reached its end-of-program store", what);
    end
  endtask

  // marker store and self-loop
  task automatic end_program();
    prog.push_back(enc_sw(12'h3fc, 0, 0));
    prog.push_back(enc_j(21'd0, 0));
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int n;
    prog.delete();
    end_program();
    start_run();
    n = 0;
    // sampled before the edge updates anything
    @(posedge clk);
    while (rst && n < 10) begin
      checks++;
      if (bup_req || bud_req) begin
        errors++;
        $display("ERR %0t: request high during reset", $time);
      end
      @(posedge clk);
      n++;
    end
    checks++;
    if (bup_req || bud_req) begin
      errors++;
      $display("ERR %0t: request high on first clock after reset", $time);
    end
    n = 0;
    while (!bup_req && n < 10) begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (!bup_req) begin
      errors++;
      $display("fetch request never rose after reset");
    end else if (bup_adr !== 32'h0) begin
      errors++;
      $display("ERR %0t: first fetch address %h expected 0", $time, bup_adr);
    end
    finish_run("reset");
  endtask

  task automatic test_arith();
    logic [11:0] a12;
    logic [11:0] b12;
    logic [11:0] c12;
    logic [6:0]  f7 [10];
    logic [2:0]  f3 [10];
    f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    a12 = $urandom;
    b12 = $urandom;
    c12 = $urandom;
    prog.delete();
    prog.push_back(enc_i(a12, 0, 3'd0, 1, rp_pkg::OPC_IMM));
    prog.push_back(enc_i(b12, 0, 3'd0, 2, rp_pkg::OPC_IMM));
    for (int k = 0; k < 10; k++) begin
      prog.push_back(enc_r(f7[k], 2, 1, f3[k], 3));
      prog.push_back(enc_sw(12'(4 * k), 3, 0));
    end
    prog.push_back(enc_i(c12, 1, 3'd0, 3, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd40, 3, 0));
    // slli by 7, srai by 9
    prog.push_back(enc_i(12'h007, 1, 3'd1, 3, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd44, 3, 0));
    prog.push_back(enc_i(12'h409, 1, 3'd5, 3, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd48, 3, 0));
    // x0 must stay zero
    prog.push_back(enc_i(12'd5, 0, 3'd0, 0, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd52, 0, 0));
    end_program();
    start_run();
    finish_run("arith");
    for (int k = 0; k < 10; k++) begin
      check_word("arith", k, expect_r(k, sext12(a12), sext12(b12)));
    end
    check_word("addi", 10, sext12(a12) + sext12(c12));
    check_word("slli", 11, sext12(a12) << 7);
    check_word("srai", 12, $signed(sext12(a12)) >>> 9);
    check_word("x0", 13, 32'h0);
  endtask

  task automatic test_upper();
    logic [19:0] u1;
    logic [19:0] u2;
    u1 = $urandom;
    u2 = $urandom;
    // rs1 field of the lui word points at x5, which is not zero
    u1[7:3] = 5'd5;
    prog.delete();
    prog.push_back(enc_i(12'h5a5, 0, 3'd0, 5, rp_pkg::OPC_IMM));
    prog.push_back(enc_u(u1, 1, rp_pkg::OPC_LUI));
    // auipc sits at address 8
    prog.push_back(enc_u(u2, 2, rp_pkg::OPC_AUIPC));
    prog.push_back(enc_sw(12'd0, 1, 0));
    prog.push_back(enc_sw(12'd4, 2, 0));
    end_program();
    start_run();
    finish_run("upper");
    check_word("lui", 0, {u1, 12'h0});
    check_word("auipc", 1, {u2, 12'h0} + 32'd8);
  endtask

  task automatic test_branch();
    logic [11:0] pa [3];
    logic [11:0] pb [3];
    logic [2:0]  f3 [6];
    int          s;
    logic        tk;
    pa = '{12'd5, 12'hffd, 12'd2};
    pb = '{12'd5, 12'd2, 12'hffd};
    f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    prog.delete();
    prog.push_back(enc_i(12'd1, 0, 3'd0, 3, rp_pkg::OPC_IMM));
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        s = 2 * (c * 3 + p);
        prog.push_back(enc_i(pa[p], 0, 3'd0, 1, rp_pkg::OPC_IMM));
        prog.push_back(enc_i(pb[p], 0, 3'd0, 2, rp_pkg::OPC_IMM));
        prog.push_back(enc_b(13'd12, 2, 1, f3[c]));
        // fall-through path marks the low word and jumps over the taken store
        prog.push_back(enc_sw(12'(4 * s), 3, 0));
        prog.push_back(enc_j(21'd8, 0));
        prog.push_back(enc_sw(12'(4 * s + 4), 3, 0));
      end
    end
    end_program();
    start_run();
    finish_run("branch");
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        s = 2 * (c * 3 + p);
        tk = branch_taken(f3[c], sext12(pa[p]), sext12(pb[p]));
        check_word("branch skipped path", s, tk ? fill_word(s) : 32'd1);
        check_word("branch target path", s + 1, tk ? 32'd1 : fill_word(s + 1));
      end
    end
  endtask

  task automatic test_jump();
    prog.delete();
    prog.push_back(enc_j(21'd12, 1));
    prog.push_back(enc_i(12'd1, 0, 3'd0, 7, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd0, 7, 0));
    prog.push_back(enc_sw(12'd4, 1, 0));
    prog.push_back(enc_i(12'd31, 0, 3'd0, 2, rp_pkg::OPC_IMM));
    // 31 + 2 is 33, bit 0 dropped lands on 32
    prog.push_back(enc_i(12'd2, 2, 3'd0, 4, rp_pkg::OPC_JALR));
    prog.push_back(enc_i(12'd1, 0, 3'd0, 7, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd8, 7, 0));
    prog.push_back(enc_sw(12'd12, 4, 0));
    end_program();
    start_run();
    finish_run("jump");
    check_word("jal skipped", 0, fill_word(0));
    check_word("jal link", 1, 32'd4);
    check_word("jalr skipped", 2, fill_word(2));
    check_word("jalr link", 3, 32'd24);
  endtask

  task automatic test_ldst();
    logic [31:0] v;
    logic [31:0] w;
    logic [11:0] lo;
    logic [31:0] hi;
    v = $urandom;
    w = $urandom;
    lo = v[11:0];
    hi = (v - sext12(lo)) >> 12;
    prog.delete();
    prog.push_back(enc_u(hi[19:0], 1, rp_pkg::OPC_LUI));
    prog.push_back(enc_i(lo, 1, 3'd0, 1, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd64, 1, 0));
    prog.push_back(enc_i(12'd64, 0, 3'd2, 2, rp_pkg::OPC_LOAD));
    // loaded register used right away
    prog.push_back(enc_i(12'd1, 2, 3'd0, 3, rp_pkg::OPC_IMM));
    prog.push_back(enc_sw(12'd68, 3, 0));
    prog.push_back(enc_i(12'd160, 0, 3'd2, 4, rp_pkg::OPC_LOAD));
    prog.push_back(enc_r(7'h00, 2, 4, 3'd0, 5));
    prog.push_back(enc_sw(12'd72, 5, 0));
    prog.push_back(enc_sw(12'd76, 4, 0));
    end_program();
    start_run();
    mem.dmem[40] = w;
    finish_run("load/store");
    check_word("sw", 16, v);
    check_word("lw use", 17, v + 32'd1);
    check_word("lw add", 18, w + v);
    check_word("lw preset", 19, w);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    rerun = 1'b0;
    seed = 32'h940d_7fc6;
    void'($urandom(seed));
    @(negedge clk);
    test_reset();
    test_arith();
    test_upper();
    test_branch();
    test_jump();
    test_ldst();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: testbench/rp_tb_mem.sv
`timescale 1ns/100ps

module rp_tb_mem (
  input  logic        clk,
  // program bus
  input  logic        bup_req,
  input  logic [31:0] bup_adr,
  output logic [31:0] bup_rdt,
  output logic        bup_ack,
  // data bus
  input  logic        bud_req,
  input  logic        bud_wen,
  input  logic [3:0]  bud_sel,
  input  logic [31:0] bud_adr,
  input  logic [31:0] bud_wdt,
  output logic [31:0] bud_rdt,
  output logic        bud_ack,
  // end-of-program store seen
  output logic        done
);

  localparam logic [31:0] MARK = 32'h0000_03fc;

  logic [31:0] pmem [256];
  logic [31:0] dmem [256];
  logic        hold;
  int unsigned wcnt;
  logic [31:0] lane;

  initial begin
    hold = 1'b0;
    wcnt = 0;
    done = 1'b0;
  end

  // word stays on rdt even while ack is withheld
  assign bup_rdt = pmem[bup_adr[9:2]];
  assign bup_ack = bup_req & ~hold;

  assign bud_rdt = dmem[bud_adr[9:2]];
  assign bud_ack = bud_req & (wcnt == 0);

  // byte lanes written under sel
  assign lane = {{8{bud_sel[3]}}, {8{bud_sel[2]}}, {8{bud_sel[1]}}, {8{bud_sel[0]}}};

  ////////////////////////////////////////////////////////////
  // wait states, changed on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    // roughly one fetch in four withheld
    hold <= (($urandom % 4) == 0);
    if (bud_req && (wcnt != 0)) begin
      wcnt <= wcnt - 1;
    end
  end

  // transfer completes at the rising edge of the ack cycle
  always @(posedge clk) begin
    if (bud_ack) begin
      if (bud_wen) begin
        dmem[bud_adr[9:2]] <= (dmem[bud_adr[9:2]] & ~lane) | (bud_wdt & lane);
        if (bud_adr == MARK) begin
          done <= 1'b1;
        end
      end
      // 0 to 2 waits before the next transfer
      wcnt <= $urandom % 3;
    end
  end

endmodule

// File: testbench/rp_tb_clk.sv
`timescale 1ns/100ps

module rp_tb_clk (
  input  logic rerun,
  output logic clk,
  output logic rst
);

  // cycles of reset left
  int unsigned cnt;

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    cnt = 3;
  end

  // 8 ns period
  always #4 clk = ~clk;

  // reset held across 3 rising edges, released on a falling edge
  always @(negedge clk) begin
    if (rerun) begin
      cnt = 3;
      rst <= 1'b1;
    end else if (cnt > 1) begin
      cnt = cnt - 1;
    end else begin
      cnt = 0;
      rst <= 1'b0;
    end
  end

endmodule

// File: hdl/rp32_core.sv
`timescale 1ns/100ps

module rp32_core #(
  parameter int unsigned RVE = 0,
  parameter logic [31:0] PC0 = 32'h0000_0000
)(
  input  logic                    clk,
  input  logic                    rst,
  // program bus
  output logic                    bup_req,
  output logic [rp_pkg::XW-1:0]   bup_adr,
  input  logic [rp_pkg::XW-1:0]   bup_rdt,
  input  logic                    bup_ack,
  // data bus
  output logic                    bud_req,
  output logic                    bud_wen,
  output logic [rp_pkg::XW/8-1:0] bud_sel,
  output logic [rp_pkg::XW-1:0]   bud_adr,
  output logic [rp_pkg::XW-1:0]   bud_wdt,
  input  logic [rp_pkg::XW-1:0]   bud_rdt,
  input  logic                    bud_ack
);

  // rv32e has 16 registers
  localparam int unsigned AW = (RVE != 0) ? 4 : 5;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // fetch
  logic [rp_pkg::XW-1:0] pc;
  logic [rp_pkg::XW-1:0] pc4;
  logic [rp_pkg::XW-1:0] pcn;
  logic                  tkn;
  logic                  stall;

  // decode
  rp_pkg::frm32_t        inst;
  logic                  jalr;
  logic [AW-1:0]         rs1_adr;

  // register file
  logic                  gpr_wen;
  logic [rp_pkg::XW-1:0] gpr_rs1;
  logic [rp_pkg::XW-1:0] gpr_rs2;
  logic [rp_pkg::XW-1:0] gpr_rd;

  // alu
  logic [rp_pkg::XW-1:0] alu_rs1;
  logic [rp_pkg::XW-1:0] alu_rs2;
  logic [rp_pkg::XW-1:0] alu_rd;
  logic [rp_pkg::XW-1:0] alu_sum;

  rp_ctl_if ctl_if ();

  ////////////////////////////////////////////////////////////
  // fetch and program counter
  ////////////////////////////////////////////////////////////

  // request rises on first clock after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bup_req <= 1'b0;
    end else begin
      bup_req <= 1'b1;
    end
  end

  // hold pc while fetch or data access waits
  assign stall = ~bup_ack | ((ctl_if.ld | ctl_if.st) & ~bud_ack);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= PC0;
    end else if (!stall) begin
      pc <= pcn;
    end
  end

  assign bup_adr = pc;
  assign pc4     = pc + 32'd4;

  // jalr target drops bit 0
  assign jalr = (inst.i.opcode == rp_pkg::OPC_JALR);
  assign pcn  = tkn ? (jalr ? {alu_sum[rp_pkg::XW-1:1], 1'b0} : alu_sum) : pc4;

  ////////////////////////////////////////////////////////////
  // decode and registers
  ////////////////////////////////////////////////////////////

  assign inst = bup_rdt;

  rp_dec dec (
    .inst  (inst),
    .valid (bup_ack),
    .ctl   (ctl_if.dec)
  );

  // lui field overlaps rs1, point it at x0
  assign rs1_adr = (inst.u.opcode == rp_pkg::OPC_LUI) ? '0 : inst.r.rs1[AW-1:0];

  // retire only when nothing waits
  assign gpr_wen = ctl_if.wbe & ~stall;

  rp_gpr #(
    .AW (AW)
  ) gpr (
    .clk   (clk),
    .rst   (rst),
    .wen   (gpr_wen),
    .a_rs1 (rs1_adr),
    .a_rs2 (inst.r.rs2[AW-1:0]),
    .a_rd  (inst.r.rd[AW-1:0]),
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  ////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////

  // operand muxes
  assign alu_rs1 = (ctl_if.a1 == rp_pkg::A1_PC)  ? pc         : gpr_rs1;
  assign alu_rs2 = (ctl_if.a2 == rp_pkg::A2_IMM) ? ctl_if.imm : gpr_rs2;

  rp_alu alu (
    .ao  (ctl_if.ao),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  // compare always on register values
  rp_br br (
    .br  (ctl_if.br),
    .rs1 (gpr_rs1),
    .rs2 (gpr_rs2),
    .tkn (tkn)
  );

  ////////////////////////////////////////////////////////////
  // load/store and write-back
  ////////////////////////////////////////////////////////////

  // word accesses only
  assign bud_req = ctl_if.ld | ctl_if.st;
  assign bud_wen = ctl_if.st;
  assign bud_sel = '1;
  assign bud_adr = alu_sum;
  assign bud_wdt = gpr_rs2;

  always_comb begin
    case (ctl_if.wb)
      rp_pkg::WB_PC4: gpr_rd = pc4;
      rp_pkg::WB_MEM: gpr_rd = bud_rdt;
      default:        gpr_rd = alu_rd;
    endcase
  end

endmodule

// File: hdl/rp_br.sv
`timescale 1ns/100ps

module rp_br (
  input  logic [2:0]            br,
  input  logic [rp_pkg::XW-1:0] rs1,
  input  logic [rp_pkg::XW-1:0] rs2,
  output logic                  tkn
);

  always_comb begin
    case (br)
      rp_pkg::BR_EQ:  tkn = (rs1 == rs2);
      rp_pkg::BR_NE:  tkn = (rs1 != rs2);
      // signed compares
      rp_pkg::BR_LT:  tkn = ($signed(rs1) <  $signed(rs2));
      rp_pkg::BR_GE:  tkn = ($signed(rs1) >= $signed(rs2));
      // unsigned compares
      rp_pkg::BR_LTU: tkn = (rs1 <  rs2);
      rp_pkg::BR_GEU: tkn = (rs1 >= rs2);
      rp_pkg::BR_JMP: tkn = 1'b1;
      default:        tkn = 1'b0;
    endcase
  end

endmodule

// File: hdl/rp_alu.sv
`timescale 1ns/100ps

module rp_alu (
  input  logic [3:0]            ao,
  input  logic [rp_pkg::XW-1:0] rs1,
  input  logic [rp_pkg::XW-1:0] rs2,
  output logic [rp_pkg::XW-1:0] rd,
  output logic [rp_pkg::XW-1:0] sum
);

  // shift amount
  logic [4:0] sh;

  assign sh = rs2[4:0];

  // address adder, independent of ao
  assign sum = rs1 + rs2;

  always_comb begin
    case (ao)
      rp_pkg::AO_ADD:  rd = sum;
      rp_pkg::AO_SUB:  rd = rs1 - rs2;
      rp_pkg::AO_SLL:  rd = rs1 << sh;
      rp_pkg::AO_SLT:  rd = {{(rp_pkg::XW-1){1'b0}}, $signed(rs1) < $signed(rs2)};
      rp_pkg::AO_SLTU: rd = {{(rp_pkg::XW-1){1'b0}}, rs1 < rs2};
      rp_pkg::AO_XOR:  rd = rs1 ^ rs2;
      rp_pkg::AO_SRL:  rd = rs1 >> sh;
      rp_pkg::AO_SRA:  rd = $unsigned($signed(rs1) >>> sh);
      rp_pkg::AO_OR:   rd = rs1 | rs2;
      rp_pkg::AO_AND:  rd = rs1 & rs2;
      default:         rd = sum;
    endcase
  end

endmodule

// File: hdl/rp_gpr.sv
`timescale 1ns/100ps

module rp_gpr #(
  parameter int unsigned AW = 5
)(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wen,
  input  logic [AW-1:0]         a_rs1,
  input  logic [AW-1:0]         a_rs2,
  input  logic [AW-1:0]         a_rd,
  input  logic [rp_pkg::XW-1:0] d_rd,
  output logic [rp_pkg::XW-1:0] d_rs1,
  output logic [rp_pkg::XW-1:0] d_rs2
);

  // register array
  logic [rp_pkg::XW-1:0] gpr [2**AW];

  // write port, x0 never written
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 2**AW; i++) begin
        gpr[i] <= '0;
      end
    end else if (wen && (a_rd != '0)) begin
      gpr[a_rd] <= d_rd;
    end
  end

  // async read ports
  assign d_rs1 = (a_rs1 == '0) ? '0 : gpr[a_rs1];
  assign d_rs2 = (a_rs2 == '0) ? '0 : gpr[a_rs2];

endmodule

// File: hdl/rp_dec.sv
`timescale 1ns/100ps

module rp_dec (
  input  rp_pkg::frm32_t inst,
  input  logic           valid,
  rp_ctl_if.dec          ctl
);

  // alu code from func3, alt is instruction bit 30
  function automatic logic [3:0] alu_op(
    input logic [2:0] f3,
    input logic       alt,
    input logic       sub_ok
  );
    logic [3:0] op;
    case (f3)
      3'b000: op = (alt && sub_ok) ? rp_pkg::AO_SUB : rp_pkg::AO_ADD;
      3'b001: op = rp_pkg::AO_SLL;
      3'b010: op = rp_pkg::AO_SLT;
      3'b011: op = rp_pkg::AO_SLTU;
      3'b100: op = rp_pkg::AO_XOR;
      3'b101: op = alt ? rp_pkg::AO_SRA : rp_pkg::AO_SRL;
      3'b110: op = rp_pkg::AO_OR;
      default: op = rp_pkg::AO_AND;
    endcase
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // defaults give a no-op
    ctl.ao  = rp_pkg::AO_ADD;
    ctl.br  = rp_pkg::BR_NONE;
    ctl.a1  = rp_pkg::A1_RS1;
    ctl.a2  = rp_pkg::A2_RS2;
    ctl.imm = '0;
    ctl.wbe = 1'b0;
    ctl.wb  = rp_pkg::WB_ALU;
    ctl.ld  = 1'b0;
    ctl.st  = 1'b0;
    case (inst.r.opcode)
      rp_pkg::OPC_OP: begin
        ctl.ao  = alu_op(inst.r.func3, inst.r.func7[5], 1'b1);
        ctl.wbe = 1'b1;
      end
      rp_pkg::OPC_IMM: begin
        // bit 30 only matters for srai
        ctl.ao  = alu_op(inst.i.func3, inst.r.func7[5], 1'b0);
        ctl.a2  = rp_pkg::A2_IMM;
        ctl.imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        ctl.wbe = 1'b1;
      end
      rp_pkg::OPC_LUI: begin
        // rs1 reads x0 here
        ctl.a2  = rp_pkg::A2_IMM;
        ctl.imm = {inst.u.imm_31_12, 12'h000};
        ctl.wbe = 1'b1;
      end
      rp_pkg::OPC_AUIPC: begin
        ctl.a1  = rp_pkg::A1_PC;
        ctl.a2  = rp_pkg::A2_IMM;
        ctl.imm = {inst.u.imm_31_12, 12'h000};
        ctl.wbe = 1'b1;
      end
      rp_pkg::OPC_JAL: begin
        ctl.br  = rp_pkg::BR_JMP;
        ctl.a1  = rp_pkg::A1_PC;
        ctl.a2  = rp_pkg::A2_IMM;
        ctl.imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                   inst.j.imm_11, inst.j.imm_10_1, 1'b0};
        ctl.wbe = 1'b1;
        ctl.wb  = rp_pkg::WB_PC4;
      end
      rp_pkg::OPC_JALR: begin
        ctl.br  = rp_pkg::BR_JMP;
        ctl.a2  = rp_pkg::A2_IMM;
        ctl.imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        ctl.wbe = 1'b1;
        ctl.wb  = rp_pkg::WB_PC4;
      end
      rp_pkg::OPC_BRANCH: begin
        // target is pc + imm, compare on rs1/rs2
        ctl.a1  = rp_pkg::A1_PC;
        ctl.a2  = rp_pkg::A2_IMM;
        ctl.imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                   inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
        case (inst.b.func3)
          3'b000:  ctl.br = rp_pkg::BR_EQ;
          3'b001:  ctl.br = rp_pkg::BR_NE;
          3'b100:  ctl.br = rp_pkg::BR_LT;
          3'b101:  ctl.br = rp_pkg::BR_GE;
          3'b110:  ctl.br = rp_pkg::BR_LTU;
          3'b111:  ctl.br = rp_pkg::BR_GEU;
          default: ctl.br = rp_pkg::BR_NONE;
        endcase
      end
      rp_pkg::OPC_LOAD: begin
        // word only
        if (inst.i.func3 == 3'b010) begin
          ctl.a2  = rp_pkg::A2_IMM;
          ctl.imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
          ctl.ld  = 1'b1;
          ctl.wbe = 1'b1;
          ctl.wb  = rp_pkg::WB_MEM;
        end
      end
      rp_pkg::OPC_STORE: begin
        if (inst.s.func3 == 3'b010) begin
          ctl.a2  = rp_pkg::A2_IMM;
          ctl.imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
          ctl.st  = 1'b1;
        end
      end
      default: begin
        // fence, system and others fall through as no-op
      end
    endcase
    // no side effects without a fetched word
    if (!valid) begin
      ctl.wbe = 1'b0;
      ctl.ld  = 1'b0;
      ctl.st  = 1'b0;
    end
  end

endmodule

// File: hdl/rp_ctl_if.sv
`timescale 1ns/100ps

interface rp_ctl_if;

  // execute controls
  logic [3:0]             ao;
  logic [2:0]             br;
  logic                   a1;
  logic                   a2;
  logic [rp_pkg::XW-1:0]  imm;

  // write-back and memory controls
  logic                   wbe;
  logic [1:0]             wb;
  logic                   ld;
  logic                   st;

  // decoder side
  modport dec (
    output ao, br, a1, a2, imm, wbe, wb, ld, st
  );

  // datapath side
  modport exe (
    input  ao, br, a1, a2, imm, wbe, wb, ld, st
  );

endinterface

// File: hdl/rp_pkg.sv
package rp_pkg;

  ////////////////////////////////////////////////////////////
  // word width
  ////////////////////////////////////////////////////////////

  localparam int unsigned XW = 32;

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  ////////////////////////////////////////////////////////////
  // alu operations, low 3 bits follow func3
  ////////////////////////////////////////////////////////////

  localparam logic [3:0] AO_ADD  = 4'b0000;
  localparam logic [3:0] AO_SUB  = 4'b1000;
  localparam logic [3:0] AO_SLL  = 4'b0001;
  localparam logic [3:0] AO_SLT  = 4'b0010;
  localparam logic [3:0] AO_SLTU = 4'b0011;
  localparam logic [3:0] AO_XOR  = 4'b0100;
  localparam logic [3:0] AO_SRL  = 4'b0101;
  localparam logic [3:0] AO_SRA  = 4'b1101;
  localparam logic [3:0] AO_OR   = 4'b0110;
  localparam logic [3:0] AO_AND  = 4'b0111;

  // branch conditions
  localparam logic [2:0] BR_NONE = 3'b000;
  localparam logic [2:0] BR_EQ   = 3'b001;
  localparam logic [2:0] BR_NE   = 3'b010;
  localparam logic [2:0] BR_LT   = 3'b011;
  localparam logic [2:0] BR_GE   = 3'b100;
  localparam logic [2:0] BR_LTU  = 3'b101;
  localparam logic [2:0] BR_GEU  = 3'b110;
  localparam logic [2:0] BR_JMP  = 3'b111;

  // operand selects
  localparam logic A1_RS1 = 1'b0;
  localparam logic A1_PC  = 1'b1;
  localparam logic A2_RS2 = 1'b0;
  localparam logic A2_IMM = 1'b1;

  // write-back source
  localparam logic [1:0] WB_ALU = 2'd0;
  localparam logic [1:0] WB_PC4 = 2'd1;
  localparam logic [1:0] WB_MEM = 2'd2;

  ////////////////////////////////////////////////////////////
  // instruction word, one view per format
  ////////////////////////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic [6:0] func7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] func3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  func3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] func3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] func3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } frm32_t;

endpackage
